//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_eth_cmd_top
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qxF '** PASS **' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- all.f
eth_cmd_frame_pkg.sv
eth_cmd_op_pkg.sv
cmd_fifo.sv
cmd_frame_parse.sv
cmd_exec.sv
eth_cmd_top.sv
tb_eth_cmd_top.sv

//--- cmd_exec.sv
`timescale 1ns/100ps

module cmd_exec (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [eth_cmd_frame_pkg::fifo_aw:0]  count,
    input  logic [eth_cmd_frame_pkg::len_w-1:0]  frame_len,
    output logic                                 fs,
    input  logic                                 fd,
    input  logic                                 err,
    input  logic [7:0]                           cmd0,
    input  logic [7:0]                           cmd1,
    input  logic [7:0]                           cmd2,
    input  logic [7:0]                           cmd3,
    input  logic [7:0]                           cmd4,
    input  logic [7:0]                           cmd5,
    input  logic [7:0]                           cmd6,
    input  logic [7:0]                           cmd7,
    input  logic [7:0]                           cmd8,
    output logic [eth_cmd_op_pkg::rate_w-1:0]    sample_rate,
    output logic [eth_cmd_op_pkg::gain_w-1:0]    gain,
    output logic [eth_cmd_op_pkg::chan_w-1:0]    chan_mask,
    output logic                                 write_done,
    output logic                                 frame_err,
    output logic                                 bad_op
);

    typedef enum logic [1:0] {
        ex_idle,
        ex_run,
        ex_drain
    } exec_state_t;

    exec_state_t state;
    logic [eth_cmd_frame_pkg::len_w-1:0] count_ext;
    logic apply;

    assign count_ext = {{(eth_cmd_frame_pkg::len_w - eth_cmd_frame_pkg::fifo_aw - 1){1'b0}},
                        count};

    // first cycle of fd in a run.
    assign apply = (state == ex_run) && fd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ex_idle;
            fs    <= 1'b0;
        end else begin
            case (state)
                ex_idle: begin
                    // start only once the whole frame sits in the FIFO.
                    if (count_ext >= frame_len) begin
                        fs    <= 1'b1;
                        state <= ex_run;
                    end
                end
                ex_run: begin
                    if (fd) begin
                        fs    <= 1'b0;
                        state <= ex_drain;
                    end
                end
                ex_drain: begin
                    if (!fd) begin
                        state <= ex_idle;
                    end
                end
                default: state <= ex_idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_rate <= eth_cmd_op_pkg::rate_rst;
            gain        <= eth_cmd_op_pkg::gain_rst;
            chan_mask   <= eth_cmd_op_pkg::chan_rst;
            write_done  <= 1'b0;
            frame_err   <= 1'b0;
            bad_op      <= 1'b0;
        end else begin
            write_done <= 1'b0;
            frame_err  <= 1'b0;
            bad_op     <= 1'b0;
            if (apply && err) begin
                frame_err <= 1'b1;
            end else if (apply) begin
                case (eth_cmd_op_pkg::cmd_op_t'(cmd0))
                    eth_cmd_op_pkg::op_nop:        ;
                    eth_cmd_op_pkg::op_set_rate:   sample_rate <= {cmd1, cmd2, cmd3, cmd4};
                    eth_cmd_op_pkg::op_set_gain:   gain <= cmd1;
                    eth_cmd_op_pkg::op_set_chan:   chan_mask <= cmd1;
                    eth_cmd_op_pkg::op_write_done: write_done <= 1'b1;
                    default:                       bad_op <= 1'b1;
                endcase
            end
        end
    end

    a_one_pulse: assert property (
        @(posedge clk) disable iff (rst) $onehot0({write_done, frame_err, bad_op})
    ) else $error("more than one event pulse");

endmodule

//--- cmd_fifo.sv
`timescale 1ns/100ps

module cmd_fifo (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               wr_en,
    input  logic [7:0]                         wr_data,
    input  logic                               rd_en,
    output logic [7:0]                         rd_data,
    output logic [eth_cmd_frame_pkg::fifo_aw:0] count
);

    logic [7:0] mem [0:eth_cmd_frame_pkg::fifo_depth-1];
    logic [eth_cmd_frame_pkg::fifo_aw-1:0] wr_ptr;
    logic [eth_cmd_frame_pkg::fifo_aw-1:0] rd_ptr;
    logic wr_ok;
    logic rd_ok;

    // a write into a full buffer is lost.
    assign wr_ok = wr_en && (count != eth_cmd_frame_pkg::fifo_depth);
    assign rd_ok = rd_en && (count != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // registered read port, data one cycle after rd_en.
    always_ff @(posedge clk) begin
        if (rd_ok) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // the parser only starts on a complete frame, so it never drains past empty.
    a_no_read_empty: assert property (
        @(posedge clk) disable iff (rst) rd_en |-> (count != '0)
    ) else $error("cmd_fifo read while empty");

endmodule

//--- cmd_frame_parse.sv
`timescale 1ns/100ps

module cmd_frame_parse (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 fs,
    output logic                                 fd,
    output logic                                 rd_en,
    input  logic [7:0]                           rd_data,
    input  logic [eth_cmd_frame_pkg::len_w-1:0]  frame_len,
    output logic                                 err,
    output logic [7:0]                           cmd0,
    output logic [7:0]                           cmd1,
    output logic [7:0]                           cmd2,
    output logic [7:0]                           cmd3,
    output logic [7:0]                           cmd4,
    output logic [7:0]                           cmd5,
    output logic [7:0]                           cmd6,
    output logic [7:0]                           cmd7,
    output logic [7:0]                           cmd8
);

    eth_cmd_frame_pkg::parse_state_t state;
    eth_cmd_frame_pkg::parse_state_t next_state;

    logic [eth_cmd_frame_pkg::len_w-1:0] idx;
    logic [eth_cmd_frame_pkg::len_w-1:0] last_idx;
    logic [eth_cmd_frame_pkg::len_w-1:0] sum_end;
    logic [7:0] cache [0:eth_cmd_frame_pkg::frame_max_len-1];
    logic [7:0] cmd_q [0:eth_cmd_frame_pkg::cmd_len-1];
    logic [7:0] sum;
    logic hdr_ok;
    logic sum_ok;

    assign last_idx = frame_len - 1'b1;
    assign sum_end  = frame_len - 2'd2;

    assign fd = (state == eth_cmd_frame_pkg::last);

    // one read in pre1, then one per work cycle except the last capture.
    assign rd_en = (state == eth_cmd_frame_pkg::pre1) ||
                   ((state == eth_cmd_frame_pkg::work) && (idx != last_idx));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= eth_cmd_frame_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            eth_cmd_frame_pkg::idle: begin
                if (fs) begin
                    next_state = eth_cmd_frame_pkg::pre0;
                end
            end
            eth_cmd_frame_pkg::pre0: next_state = eth_cmd_frame_pkg::pre1;
            eth_cmd_frame_pkg::pre1: next_state = eth_cmd_frame_pkg::work;
            eth_cmd_frame_pkg::work: begin
                if (idx == last_idx) begin
                    next_state = eth_cmd_frame_pkg::chk0;
                end
            end
            eth_cmd_frame_pkg::chk0: next_state = eth_cmd_frame_pkg::prec;
            eth_cmd_frame_pkg::prec: begin
                if (idx == sum_end) begin
                    next_state = eth_cmd_frame_pkg::chk1;
                end
            end
            eth_cmd_frame_pkg::chk1: next_state = eth_cmd_frame_pkg::evac;
            eth_cmd_frame_pkg::evac: next_state = eth_cmd_frame_pkg::last;
            eth_cmd_frame_pkg::last: begin
                if (!fs) begin
                    next_state = eth_cmd_frame_pkg::idle;
                end
            end
            default: next_state = eth_cmd_frame_pkg::idle;
        endcase
    end

    // capture index while reading, then byte index for the checksum pass.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx <= '0;
        end else if (state == eth_cmd_frame_pkg::pre0) begin
            idx <= '0;
        end else if (state == eth_cmd_frame_pkg::chk0) begin
            idx <= eth_cmd_frame_pkg::len_w'(eth_cmd_frame_pkg::hdr_len);
        end else if (state == eth_cmd_frame_pkg::work || state == eth_cmd_frame_pkg::prec) begin
            idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == eth_cmd_frame_pkg::work) begin
            cache[idx[eth_cmd_frame_pkg::cache_aw-1:0]] <= rd_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum    <= 8'h00;
            hdr_ok <= 1'b0;
            sum_ok <= 1'b0;
        end else begin
            case (state)
                eth_cmd_frame_pkg::chk0: begin
                    sum    <= 8'h00;
                    hdr_ok <= ({cache[0], cache[1]} == eth_cmd_frame_pkg::frame_hdr);
                end
                eth_cmd_frame_pkg::prec: begin
                    sum <= sum + cache[idx[eth_cmd_frame_pkg::cache_aw-1:0]];
                end
                eth_cmd_frame_pkg::chk1: begin
                    sum_ok <= (sum == cache[last_idx[eth_cmd_frame_pkg::cache_aw-1:0]]);
                end
                default: begin
                    sum <= sum;
                end
            endcase
        end
    end

    // a rejected frame reads back as all ones.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            err <= 1'b0;
            for (int i = 0; i < eth_cmd_frame_pkg::cmd_len; i++) begin
                cmd_q[i] <= 8'h00;
            end
        end else if (state == eth_cmd_frame_pkg::evac) begin
            err <= !(hdr_ok && sum_ok);
            for (int i = 0; i < eth_cmd_frame_pkg::cmd_len; i++) begin
                cmd_q[i] <= (hdr_ok && sum_ok) ? cache[eth_cmd_frame_pkg::hdr_len + i] : 8'hff;
            end
        end
    end

    assign cmd0 = cmd_q[0];
    assign cmd1 = cmd_q[1];
    assign cmd2 = cmd_q[2];
    assign cmd3 = cmd_q[3];
    assign cmd4 = cmd_q[4];
    assign cmd5 = cmd_q[5];
    assign cmd6 = cmd_q[6];
    assign cmd7 = cmd_q[7];
    assign cmd8 = cmd_q[8];

    a_len_range: assert property (
        @(posedge clk) disable iff (rst)
        fs |-> (frame_len >= eth_cmd_frame_pkg::frame_min_len &&
                frame_len <= eth_cmd_frame_pkg::frame_max_len)
    ) else $error("frame_len %0d outside frame limits", frame_len);

    // done is only raised for a start that is still pending.
    a_fd_after_fs: assert property (
        @(posedge clk) disable iff (rst) $rose(fd) |-> fs
    ) else $error("fd raised without fs");

endmodule

//--- cmd_input.txt
# name, twelve frame bytes (hex), expected event, then sample_rate gain chan_mask (hex)
# names starting with b2b are written right behind the previous frame
set_rate   55 aa 01 00 01 77 00 00 00 00 00 79 none       00017700 01 01
set_gain   55 aa 02 08 11 22 33 44 00 00 00 b4 none       00017700 08 01
set_chan   55 aa 03 0f 01 02 03 04 05 06 07 2e none       00017700 08 0f
bad_hdr    55 ab 02 20 00 00 00 00 00 00 00 22 frame_err  00017700 08 0f
bad_sum    55 aa 03 ff 00 00 00 00 00 00 00 00 frame_err  00017700 08 0f
done       55 aa 04 00 00 00 00 00 00 00 00 04 write_done 00017700 08 0f
unknown_op 55 aa 09 11 22 00 00 00 00 00 00 3c bad_op     00017700 08 0f
nop        55 aa 00 12 34 00 00 00 00 00 00 46 none       00017700 08 0f
set_rate2  55 aa 01 00 00 3e 80 00 00 00 00 bf none       00003e80 08 0f
b2b_gain   55 aa 02 10 00 00 00 00 00 00 00 12 none       00003e80 10 0f
b2b_done   55 aa 04 00 00 00 00 00 00 00 00 04 write_done 00003e80 10 0f
b2b_chan   55 aa 03 a5 00 00 00 00 00 00 00 a8 none       00003e80 10 a5

//--- eth_cmd_frame_pkg.sv
package eth_cmd_frame_pkg;

    // width of a frame length field.
    localparam int len_w = 12;

    // frame layout: header, command bytes, one checksum byte.
    localparam logic [15:0] frame_hdr = 16'h55aa;
    localparam int hdr_len = 2;
    localparam int cmd_len = 9;

    // the cache holds 32 bytes, so no frame may be longer.
    localparam int cache_aw = 5;
    localparam logic [len_w-1:0] frame_max_len = 12'd32;
    localparam logic [len_w-1:0] frame_min_len = len_w'(hdr_len + cmd_len + 1);

    // receive byte FIFO.
    localparam int fifo_aw = 6;
    localparam logic [fifo_aw:0] fifo_depth = 7'd64;

    // parser states.
    typedef enum logic [7:0] {
        idle = 8'h00,
        pre0 = 8'h01,
        pre1 = 8'h02,
        work = 8'h03,
        chk0 = 8'h04,
        prec = 8'h05,
        chk1 = 8'h06,
        evac = 8'h0e,
        last = 8'h0f
    } parse_state_t;

endpackage

//--- eth_cmd_op_pkg.sv
package eth_cmd_op_pkg;

    // command opcodes, carried in the first command byte.
    typedef enum logic [7:0] {
        op_nop        = 8'h00,
        op_set_rate   = 8'h01,
        op_set_gain   = 8'h02,
        op_set_chan   = 8'h03,
        op_write_done = 8'h04
    } cmd_op_t;

    // configuration register widths.
    localparam int rate_w = 32;
    localparam int gain_w = 8;
    localparam int chan_w = 8;

    // power-up configuration.
    localparam logic [rate_w-1:0] rate_rst = 32'd48000;
    localparam logic [gain_w-1:0] gain_rst = 8'd1;
    // only channel 0 enabled.
    localparam logic [chan_w-1:0] chan_rst = 8'h01;

endpackage

//--- eth_cmd_top.sv
`timescale 1ns/100ps

module eth_cmd_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 rx_valid,
    input  logic [7:0]                           rx_data,
    input  logic [eth_cmd_frame_pkg::len_w-1:0]  frame_len,
    output logic [eth_cmd_op_pkg::rate_w-1:0]    sample_rate,
    output logic [eth_cmd_op_pkg::gain_w-1:0]    gain,
    output logic [eth_cmd_op_pkg::chan_w-1:0]    chan_mask,
    output logic                                 write_done,
    output logic                                 frame_err,
    output logic                                 bad_op
);

    logic [eth_cmd_frame_pkg::fifo_aw:0] fifo_count;
    logic [7:0] rd_data;
    logic rd_en;
    logic fs;
    logic fd;
    logic err;
    logic [7:0] cmd0;
    logic [7:0] cmd1;
    logic [7:0] cmd2;
    logic [7:0] cmd3;
    logic [7:0] cmd4;
    logic [7:0] cmd5;
    logic [7:0] cmd6;
    logic [7:0] cmd7;
    logic [7:0] cmd8;

    cmd_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (rx_valid),
        .wr_data (rx_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .count   (fifo_count)
    );

    cmd_frame_parse u_parse (
        .clk       (clk),
        .rst       (rst),
        .fs        (fs),
        .fd        (fd),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .frame_len (frame_len),
        .err       (err),
        .cmd0      (cmd0),
        .cmd1      (cmd1),
        .cmd2      (cmd2),
        .cmd3      (cmd3),
        .cmd4      (cmd4),
        .cmd5      (cmd5),
        .cmd6      (cmd6),
        .cmd7      (cmd7),
        .cmd8      (cmd8)
    );

    cmd_exec u_exec (
        .clk         (clk),
        .rst         (rst),
        .count       (fifo_count),
        .frame_len   (frame_len),
        .fs          (fs),
        .fd          (fd),
        .err         (err),
        .cmd0        (cmd0),
        .cmd1        (cmd1),
        .cmd2        (cmd2),
        .cmd3        (cmd3),
        .cmd4        (cmd4),
        .cmd5        (cmd5),
        .cmd6        (cmd6),
        .cmd7        (cmd7),
        .cmd8        (cmd8),
        .sample_rate (sample_rate),
        .gain        (gain),
        .chan_mask   (chan_mask),
        .write_done  (write_done),
        .frame_err   (frame_err),
        .bad_op      (bad_op)
    );

endmodule

//--- tb_eth_cmd_top.sv
`timescale 1ns/100ps

module tb_eth_cmd_top;

    localparam int frame_bytes = 12;

    typedef struct {
        string       name;
        logic [95:0] data;
        string       kind;
        logic [31:0] rate;
        logic [7:0]  gain;
        logic [7:0]  chan;
    } test_t;

    logic clk = 1'b0;
    logic rst;
    logic rx_valid;
    logic [7:0] rx_data;
    logic [eth_cmd_frame_pkg::len_w-1:0] frame_len;
    logic [eth_cmd_op_pkg::rate_w-1:0] sample_rate;
    logic [eth_cmd_op_pkg::gain_w-1:0] gain;
    logic [eth_cmd_op_pkg::chan_w-1:0] chan_mask;
    logic write_done;
    logic frame_err;
    logic bad_op;

    test_t tests[$];
    test_t expq[$];
    int n_tests = 0;
    int errors = 0;
    bit mon_on = 1'b0;
    logic [31:0] prev_rate;
    logic [7:0] prev_gain;
    logic [7:0] prev_chan;
    logic [31:0] exp_rate;
    logic [7:0] exp_gain;
    logic [7:0] exp_chan;

    eth_cmd_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .frame_len   (frame_len),
        .sample_rate (sample_rate),
        .gain        (gain),
        .chan_mask   (chan_mask),
        .write_done  (write_done),
        .frame_err   (frame_err),
        .bad_op      (bad_op)
    );

    always #10 clk = ~clk;

    function automatic bit in_burst(input string name);
        return (name.len() >= 3) && (name.substr(0, 2) == "b2b");
    endfunction

    task automatic compare_value(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            errors++;
            $display("ERR %s %s: expected %0h, actual %0h", test, what, expected, actual);
        end
    endtask

    task automatic load_tests();
        int fh;
        int n;
        string line;
        string name;
        string kind;
        logic [7:0] b [0:11];
        logic [31:0] rate;
        logic [7:0] g;
        logic [7:0] c;
        test_t t;
        fh = $fopen("cmd_input.txt", "r");
        if (fh == 0) begin
            errors++;
            $display("could not open cmd_input.txt");
            return;
        end
        while ($fgets(line, fh) > 0) begin
            if (line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %s %h %h %h", name,
                        b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7], b[8], b[9], b[10],
                        b[11], kind, rate, g, c);
            if (n <= 0) begin
                continue;
            end
            if (n != 17) begin
                errors++;
                $display("cmd_input.txt has a line that cannot be read: %s", line);
                continue;
            end
            t.name = name;
            t.data = {b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7], b[8], b[9], b[10], b[11]};
            t.kind = kind;
            t.rate = rate;
            t.gain = g;
            t.chan = c;
            tests.push_back(t);
        end
        $fclose(fh);
        n_tests = tests.size();
    endtask

    task automatic write_byte(input logic [7:0] b);
        @(posedge clk);
        #2;
        rx_valid = 1'b1;
        rx_data  = b;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            rx_valid = 1'b0;
        end
    endtask

    // burst frames go out with no gaps so the FIFO fills up.
    task automatic send_frame(input logic [95:0] data, input bit burst);
        int gap;
        for (int i = 0; i < frame_bytes; i++) begin
            write_byte(data[95 - 8 * i -: 8]);
            if (i < frame_bytes - 1) begin
                gap = burst ? 0 : $urandom_range(3, 0);
                idle_cycles(gap);
            end
        end
    endtask

    task automatic wait_results();
        int limit;
        int n;
        limit = expq.size() * (4 * int'(frame_len) + 40);
        n = 0;
        while (expq.size() != 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
    endtask

    task automatic check_reset();
        compare_value("reset", "sample_rate", eth_cmd_op_pkg::rate_rst, sample_rate);
        compare_value("reset", "gain", 32'(eth_cmd_op_pkg::gain_rst), 32'(gain));
        compare_value("reset", "chan_mask", 32'(eth_cmd_op_pkg::chan_rst), 32'(chan_mask));
        assert (!(write_done || frame_err || bad_op)) else begin
            errors++;
            $display("an event pulse was high right after reset");
        end
        prev_rate = sample_rate;
        prev_gain = gain;
        prev_chan = chan_mask;
        exp_rate  = eth_cmd_op_pkg::rate_rst;
        exp_gain  = eth_cmd_op_pkg::gain_rst;
        exp_chan  = eth_cmd_op_pkg::chan_rst;
    endtask

    task automatic check_event(input string kind);
        test_t e;
        if (expq.size() == 0) begin
            errors++;
            $display("unexpected %s event at %0t with no frame outstanding", kind, $time);
        end else begin
            e = expq.pop_front();
            assert (kind == e.kind) else begin
                errors++;
                $display("ERR %s event: expected %s, actual %s", e.name, e.kind, kind);
            end
            compare_value(e.name, "sample_rate", e.rate, sample_rate);
            compare_value(e.name, "gain", 32'(e.gain), 32'(gain));
            compare_value(e.name, "chan_mask", 32'(e.chan), 32'(chan_mask));
        end
    endtask

    // a pulse or a register change marks the result of one frame.
    always @(negedge clk) begin
        if (mon_on) begin
            if (write_done) begin
                check_event("write_done");
            end else if (frame_err) begin
                check_event("frame_err");
            end else if (bad_op) begin
                check_event("bad_op");
            end else if (sample_rate != prev_rate || gain != prev_gain ||
                         chan_mask != prev_chan) begin
                check_event("none");
            end
            prev_rate = sample_rate;
            prev_gain = gain;
            prev_chan = chan_mask;
        end
    end

    initial begin : stimulus
        test_t t;
        void'($urandom(38859));
        rst       = 1'b1;
        rx_valid  = 1'b0;
        rx_data   = 8'h00;
        frame_len = 12;
        load_tests();
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_reset();
        mon_on = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            t = tests[i];
            if (!in_burst(t.name)) begin
                wait_results();
            end
            // a nop leaves nothing to observe.
            if (t.kind != "none" || t.rate != exp_rate || t.gain != exp_gain ||
                t.chan != exp_chan) begin
                expq.push_back(t);
            end
            exp_rate = t.rate;
            exp_gain = t.gain;
            exp_chan = t.chan;
            send_frame(t.data, in_burst(t.name));
            if (i + 1 == n_tests || !in_burst(tests[i + 1].name)) begin
                idle_cycles(1);
            end
        end
        wait_results();
        // quiet window to catch stray events.
        repeat (2 * int'(frame_len) + 20) @(posedge clk);
        while (expq.size() > 0) begin
            t = expq.pop_front();
            errors++;
            $display("no result was seen for test %s, expected %s", t.name, t.kind);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        wait (n_tests > 0);
        repeat (10 + (n_tests + 1) * (4 * int'(frame_len) + 40)) @(posedge clk);
        $display("timeout, the run did not finish within the time allowed for its frames");
        $display("errors: %0d", errors);
        $display("** FAIL **");
        $finish;
    end

endmodule
